// ==== logic/board_pkg.sv ====
`default_nettype none
//------------------------------------------------
// Shared widths, register map and field types for
// the board glue logic, referenced by scoped name
//------------------------------------------------

package board_pkg;

  // AXI4-Lite bus widths
  parameter int addr_w = 32;
  parameter int data_w = 32;

  typedef logic [addr_w-1:0] reg_addr_t;
  typedef logic [data_w-1:0] reg_data_t;

  // Register word index, taken from address bits 3:2
  typedef enum logic [2:0] {
    reg_status    = 3'd0,  // byte offset 0x00
    reg_fe_ctrl0  = 3'd1,  // byte offset 0x04
    reg_fe_ctrl1  = 3'd2,  // byte offset 0x08
    reg_evt_count = 3'd3   // byte offset 0x0C
  } reg_sel_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  // Shared by the write and read channel FSMs
  typedef enum logic [1:0] {
    st_idle,
    st_resp
  } bus_state_e;

  // PLL lock, 10 MHz detected, PPS detected, reference lock
  typedef logic [3:0] tcxo_status_t;

  // Per channel front end
  // 8:6 LEDs RX, TXRX tx, TXRX rx
  // 5:2 antenna selects VCRX V2/V1, VCTXRX V2/V1
  // 1:0 TX enables B and A
  typedef logic [8:0] fe_ctrl_t;

  typedef logic [7:0] evt_count_t;

endpackage

`default_nettype wire

// ==== logic/input_sync.sv ====
`timescale 1ns/1ps
`default_nettype none
//------------------------------------------------
// Two-flop synchronizers for the slow board inputs
// Outputs lag the raw level by two bus_clk edges
//------------------------------------------------

module input_sync (
  input  wire                          bus_clk,
  input  wire                          bus_rst,
  input  wire                          onswitch_n,
  input  wire                          gps_pps,
  input  wire board_pkg::tcxo_status_t tcxo_status_raw,
  input  wire [1:0]                    lock_raw,
  output logic                         onswitch_n_s,
  output logic                         pps_s,
  output board_pkg::tcxo_status_t      tcxo_status_s,
  output logic [1:0]                   lock_s
);

  // Button, PPS, oscillator status and lock bits packed together
  localparam int sync_w = 4 + $bits(board_pkg::tcxo_status_t);

  // Button idles high (not pressed), everything else idles low
  localparam logic [sync_w-1:0] rst_val = {1'b1, {(sync_w-1){1'b0}}};

  logic [sync_w-1:0] meta_q;
  logic [sync_w-1:0] sync_q;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      meta_q <= rst_val;
      sync_q <= rst_val;
    end else begin
      meta_q <= {onswitch_n, gps_pps, tcxo_status_raw, lock_raw};
      sync_q <= meta_q;
    end
  end

  assign {onswitch_n_s, pps_s, tcxo_status_s, lock_s} = sync_q;

endmodule

`default_nettype wire

// ==== logic/button_irq_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
//------------------------------------------------
// Button press and release detection with stretched
// interrupt outputs and one-cycle event strobes
//------------------------------------------------

module button_irq_gen #(
  parameter int unsigned stretch_len = 8
) (
  input  wire  bus_clk,
  input  wire  bus_rst,
  input  wire  onswitch_n_s,
  output logic press_irq,
  output logic release_irq,
  output logic press_evt,
  output logic release_evt
);

  // Index 0 is press, index 1 is release
  logic [1:0]                  hist_q;
  logic [1:0]                  edge_flag;
  logic [1:0]                  evt_q;
  logic [1:0][stretch_len-1:0] stretch_q;

  // Button is active low
  // a press is a low level after two high samples
  assign edge_flag[0] = ~onswitch_n_s & hist_q[0] & hist_q[1];
  assign edge_flag[1] = onswitch_n_s & ~hist_q[0] & ~hist_q[1];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // History starts as released so reset gives no event
      hist_q    <= 2'b11;
      evt_q     <= '0;
      stretch_q <= '0;
    end else begin
      hist_q <= {hist_q[0], onswitch_n_s};
      evt_q  <= edge_flag;
      // Each event walks through the shift register once
      for (int i = 0; i < 2; i++) begin
        stretch_q[i] <= (stretch_q[i] << 1) | stretch_len'(edge_flag[i]);
      end
    end
  end

  // IRQ stays high while the event is anywhere in the stretcher
  assign press_irq   = |stretch_q[0];
  assign release_irq = |stretch_q[1];

  assign press_evt   = evt_q[0];
  assign release_evt = evt_q[1];

endmodule

`default_nettype wire

// ==== logic/board_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
//------------------------------------------------
// AXI4-Lite slave with board status, button event
// counters and the two front-end control registers
//------------------------------------------------

module board_ctrl_regs (
  input  wire                               bus_clk,
  input  wire                               bus_rst,
  input  wire                               pps_s,
  input  wire board_pkg::tcxo_status_t      tcxo_status_s,
  input  wire [1:0]                         lock_s,
  input  wire                               onswitch_n_s,
  input  wire                               press_evt,
  input  wire                               release_evt,
  input  wire board_pkg::reg_addr_t         s_axi_awaddr,
  input  wire                               s_axi_awvalid,
  output logic                              s_axi_awready,
  input  wire board_pkg::reg_data_t         s_axi_wdata,
  input  wire [board_pkg::data_w/8-1:0]     s_axi_wstrb,
  input  wire                               s_axi_wvalid,
  output logic                              s_axi_wready,
  output board_pkg::axi_resp_e              s_axi_bresp,
  output logic                              s_axi_bvalid,
  input  wire                               s_axi_bready,
  input  wire board_pkg::reg_addr_t         s_axi_araddr,
  input  wire                               s_axi_arvalid,
  output logic                              s_axi_arready,
  output board_pkg::reg_data_t              s_axi_rdata,
  output board_pkg::axi_resp_e              s_axi_rresp,
  output logic                              s_axi_rvalid,
  input  wire                               s_axi_rready,
  output board_pkg::fe_ctrl_t               fe_ctrl0,
  output board_pkg::fe_ctrl_t               fe_ctrl1
);

  board_pkg::bus_state_e w_state;
  board_pkg::bus_state_e r_state;
  board_pkg::axi_resp_e  bresp_q;
  board_pkg::axi_resp_e  rresp_q;
  board_pkg::reg_data_t  rdata_q;
  board_pkg::reg_data_t  rd_word;
  board_pkg::reg_sel_e   wr_sel;
  board_pkg::reg_sel_e   rd_sel;
  board_pkg::fe_ctrl_t   fe_q [2];
  board_pkg::evt_count_t press_cnt;
  board_pkg::evt_count_t release_cnt;
  logic                  wr_accept;
  logic                  wr_mapped;
  logic                  rd_accept;
  logic                  rd_mapped;
  logic                  cnt_clear;

  // Byte lane 0 carries bits 7:0, lane 1 carries bit 8
  function automatic board_pkg::fe_ctrl_t merge_fe(
    input board_pkg::fe_ctrl_t  old_val,
    input board_pkg::reg_data_t data,
    input logic [1:0]           strb
  );
    board_pkg::fe_ctrl_t new_val;
    new_val = old_val;
    if (strb[0]) begin
      new_val[7:0] = data[7:0];
    end
    if (strb[1]) begin
      new_val[8] = data[8];
    end
    return new_val;
  endfunction

  // Counters stick at all ones
  function automatic board_pkg::evt_count_t sat_inc(
    input board_pkg::evt_count_t cnt,
    input logic                  evt
  );
    if (evt && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  //------------------------------------------------
  // Write channel
  //------------------------------------------------
  assign wr_accept = (w_state == board_pkg::st_idle) && s_axi_awvalid && s_axi_wvalid;
  assign wr_mapped = (s_axi_awaddr[board_pkg::addr_w-1:4] == '0);
  assign wr_sel    = board_pkg::reg_sel_e'({1'b0, s_axi_awaddr[3:2]});
  assign cnt_clear = wr_accept && wr_mapped && (wr_sel == board_pkg::reg_evt_count);

  assign s_axi_awready = wr_accept;
  assign s_axi_wready  = wr_accept;
  assign s_axi_bvalid  = (w_state == board_pkg::st_resp);
  assign s_axi_bresp   = bresp_q;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      w_state <= board_pkg::st_idle;
      fe_q[0] <= '0;
      fe_q[1] <= '0;
    end else begin
      case (w_state)
        board_pkg::st_idle: if (wr_accept) w_state <= board_pkg::st_resp;
        board_pkg::st_resp: if (s_axi_bready) w_state <= board_pkg::st_idle;
        default:            w_state <= board_pkg::st_idle;
      endcase
      if (wr_accept && wr_mapped) begin
        case (wr_sel)
          board_pkg::reg_fe_ctrl0: fe_q[0] <= merge_fe(fe_q[0], s_axi_wdata, s_axi_wstrb[1:0]);
          board_pkg::reg_fe_ctrl1: fe_q[1] <= merge_fe(fe_q[1], s_axi_wdata, s_axi_wstrb[1:0]);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (wr_accept) begin
      bresp_q <= wr_mapped ? board_pkg::resp_okay : board_pkg::resp_slverr;
    end
  end

  // Any write to the count register clears both counts
  always_ff @(posedge bus_clk) begin
    if (bus_rst || cnt_clear) begin
      press_cnt   <= '0;
      release_cnt <= '0;
    end else begin
      press_cnt   <= sat_inc(press_cnt, press_evt);
      release_cnt <= sat_inc(release_cnt, release_evt);
    end
  end

  assign fe_ctrl0 = fe_q[0];
  assign fe_ctrl1 = fe_q[1];

  //------------------------------------------------
  // Read channel
  //------------------------------------------------
  assign rd_accept = (r_state == board_pkg::st_idle) && s_axi_arvalid;
  assign rd_mapped = (s_axi_araddr[board_pkg::addr_w-1:4] == '0);
  assign rd_sel    = board_pkg::reg_sel_e'({1'b0, s_axi_araddr[3:2]});

  always_comb begin
    case (rd_sel)
      board_pkg::reg_status:
        rd_word = board_pkg::reg_data_t'({~onswitch_n_s, lock_s, pps_s, tcxo_status_s});
      board_pkg::reg_fe_ctrl0: rd_word = board_pkg::reg_data_t'(fe_q[0]);
      board_pkg::reg_fe_ctrl1: rd_word = board_pkg::reg_data_t'(fe_q[1]);
      board_pkg::reg_evt_count:
        rd_word = board_pkg::reg_data_t'({release_cnt, press_cnt});
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      r_state <= board_pkg::st_idle;
    end else begin
      case (r_state)
        board_pkg::st_idle: if (rd_accept) r_state <= board_pkg::st_resp;
        board_pkg::st_resp: if (s_axi_rready) r_state <= board_pkg::st_idle;
        default:            r_state <= board_pkg::st_idle;
      endcase
    end
  end

  // Read data is captured at acceptance and held through back-pressure
  always_ff @(posedge bus_clk) begin
    if (rd_accept) begin
      rdata_q <= rd_mapped ? rd_word : '0;
      rresp_q <= rd_mapped ? board_pkg::resp_okay : board_pkg::resp_slverr;
    end
  end

  assign s_axi_arready = rd_accept;
  assign s_axi_rvalid  = (r_state == board_pkg::st_resp);
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = rresp_q;

endmodule

`default_nettype wire

// ==== logic/board_glue_top.sv ====
`timescale 1ns/1ps
`default_nettype none
//------------------------------------------------
// Board glue top: sync stage, button event stage
// and AXI4-Lite register stage on bus_clk
//------------------------------------------------

module board_glue_top #(
  parameter int unsigned stretch_len = 8
) (
  input  wire                           bus_clk,
  input  wire                           bus_rst,
  // Asynchronous board inputs
  input  wire                           onswitch_n,
  input  wire                           gps_pps,
  input  wire board_pkg::tcxo_status_t  tcxo_status_raw,
  input  wire [1:0]                     lock_raw,
  // AXI4-Lite slave
  input  wire board_pkg::reg_addr_t     s_axi_awaddr,
  input  wire                           s_axi_awvalid,
  output logic                          s_axi_awready,
  input  wire board_pkg::reg_data_t     s_axi_wdata,
  input  wire [board_pkg::data_w/8-1:0] s_axi_wstrb,
  input  wire                           s_axi_wvalid,
  output logic                          s_axi_wready,
  output board_pkg::axi_resp_e          s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  wire                           s_axi_bready,
  input  wire board_pkg::reg_addr_t     s_axi_araddr,
  input  wire                           s_axi_arvalid,
  output logic                          s_axi_arready,
  output board_pkg::reg_data_t          s_axi_rdata,
  output board_pkg::axi_resp_e          s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  wire                           s_axi_rready,
  // Interrupts, GPIO and front-end control
  output logic                          press_irq,
  output logic                          release_irq,
  output logic                          pps_out,
  output board_pkg::fe_ctrl_t           fe_ctrl0,
  output board_pkg::fe_ctrl_t           fe_ctrl1
);

  logic                    onswitch_n_s;
  logic                    pps_s;
  board_pkg::tcxo_status_t tcxo_status_s;
  logic [1:0]              lock_s;
  logic                    press_evt;
  logic                    release_evt;

  input_sync i_input_sync (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .onswitch_n(onswitch_n), .gps_pps(gps_pps),
    .tcxo_status_raw(tcxo_status_raw), .lock_raw(lock_raw),
    .onswitch_n_s(onswitch_n_s), .pps_s(pps_s),
    .tcxo_status_s(tcxo_status_s), .lock_s(lock_s)
  );

  button_irq_gen #(.stretch_len(stretch_len)) i_button_irq_gen (
    .bus_clk(bus_clk), .bus_rst(bus_rst), .onswitch_n_s(onswitch_n_s),
    .press_irq(press_irq), .release_irq(release_irq),
    .press_evt(press_evt), .release_evt(release_evt)
  );

  board_ctrl_regs i_board_ctrl_regs (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .pps_s(pps_s), .tcxo_status_s(tcxo_status_s), .lock_s(lock_s),
    .onswitch_n_s(onswitch_n_s), .press_evt(press_evt), .release_evt(release_evt),
    .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb),
    .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
    .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
    .fe_ctrl0(fe_ctrl0), .fe_ctrl1(fe_ctrl1)
  );

  // Synchronized PPS goes out as a GPIO for time keeping
  assign pps_out = pps_s;

endmodule

`default_nettype wire

// ==== tb/tb_board_glue.sv ====
`timescale 1ns/1ps
`default_nettype none
//------------------------------------------------
// Self-checking random testbench for board_glue_top
// Drives AXI4-Lite and board inputs, checks a model
//------------------------------------------------

module tb_board_glue;

  localparam int n_fe_writes = 200;
  localparam int n_status    = 30;
  localparam int n_events    = 40;
  localparam int n_unmapped  = 20;
  localparam int n_trans     = 3 + 2 * n_fe_writes + n_status + n_events + 4 + 5 * n_unmapped;
  localparam int wd_cycles   = (n_trans + n_events + n_status) * 100;

  integer seed = 32'h4cdd;

  logic                           bus_clk;
  logic                           bus_rst;
  logic                           onswitch_n;
  logic                           gps_pps;
  board_pkg::tcxo_status_t        tcxo_status_raw;
  logic [1:0]                     lock_raw;
  board_pkg::reg_addr_t           s_axi_awaddr;
  logic                           s_axi_awvalid;
  logic                           s_axi_awready;
  board_pkg::reg_data_t           s_axi_wdata;
  logic [board_pkg::data_w/8-1:0] s_axi_wstrb;
  logic                           s_axi_wvalid;
  logic                           s_axi_wready;
  board_pkg::axi_resp_e           s_axi_bresp;
  logic                           s_axi_bvalid;
  logic                           s_axi_bready;
  board_pkg::reg_addr_t           s_axi_araddr;
  logic                           s_axi_arvalid;
  logic                           s_axi_arready;
  board_pkg::reg_data_t           s_axi_rdata;
  board_pkg::axi_resp_e           s_axi_rresp;
  logic                           s_axi_rvalid;
  logic                           s_axi_rready;
  logic                           press_irq;
  logic                           release_irq;
  logic                           pps_out;
  board_pkg::fe_ctrl_t            fe_ctrl0;
  board_pkg::fe_ctrl_t            fe_ctrl1;

  // Reference model state
  board_pkg::fe_ctrl_t   fe_model [2];
  board_pkg::evt_count_t press_model;
  board_pkg::evt_count_t release_model;
  logic                  btn_level;

  board_glue_top #(.stretch_len(8)) i_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge bus_clk);
    $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
    $display("Result: FAILED");
    $fatal(1);
  end

  function automatic board_pkg::reg_data_t rand32();
    return $random(seed);
  endfunction

  // Bytes 0 and 1 of WSTRB gate bits 7:0 and bit 8
  function automatic board_pkg::fe_ctrl_t masked_fe(board_pkg::fe_ctrl_t old_val,
                                                    board_pkg::reg_data_t data,
                                                    logic [3:0] strb);
    board_pkg::fe_ctrl_t mask;
    mask = {strb[1], {8{strb[0]}}};
    return (old_val & ~mask) | (data[8:0] & mask);
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input board_pkg::reg_data_t got, input board_pkg::reg_data_t exp,
                            input string what);
    if (got !== exp) report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_resp(input board_pkg::axi_resp_e got, input board_pkg::axi_resp_e exp,
                            input string what);
    if (got !== exp) report_error($sformatf("%s: got %s, expected %s", what, got.name(),
                                            exp.name()));
  endtask

  task automatic check_fe(input board_pkg::fe_ctrl_t got, input board_pkg::fe_ctrl_t exp,
                          input string what);
    if (got !== exp) report_error($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_count(input board_pkg::evt_count_t got, input board_pkg::evt_count_t exp,
                             input string what);
    if (got !== exp) report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic axi_write(input board_pkg::reg_addr_t addr, input board_pkg::reg_data_t data,
                           input logic [3:0] strb, output board_pkg::axi_resp_e resp);
    int delay;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    // Idle channel takes the write in this cycle
    #1;
    if (!(s_axi_awready && s_axi_wready)) begin
      report_error("AWREADY and WREADY did not rise together on an idle channel");
    end
    do @(negedge bus_clk); while (!s_axi_bvalid);
    if (s_axi_awready || s_axi_wready) begin
      report_error("AWREADY or WREADY stayed high after the write was accepted");
    end
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    resp  = s_axi_bresp;
    delay = int'(rand32() % 4);
    repeat (delay) begin
      @(negedge bus_clk);
      if (!s_axi_bvalid) report_error("BVALID dropped while BREADY was low");
      check_resp(s_axi_bresp, resp, "BRESP under back-pressure");
    end
    s_axi_bready = 1'b1;
    @(negedge bus_clk);
    s_axi_bready = 1'b0;
    if (s_axi_bvalid) report_error("BVALID still high after the handshake");
  endtask

  task automatic axi_read(input board_pkg::reg_addr_t addr, output board_pkg::reg_data_t data,
                          output board_pkg::axi_resp_e resp);
    int delay;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    #1;
    if (!s_axi_arready) report_error("ARREADY did not rise on an idle read channel");
    do @(negedge bus_clk); while (!s_axi_rvalid);
    if (s_axi_arready) report_error("ARREADY stayed high after the read was accepted");
    s_axi_arvalid = 1'b0;
    data  = s_axi_rdata;
    resp  = s_axi_rresp;
    delay = int'(rand32() % 4);
    repeat (delay) begin
      @(negedge bus_clk);
      if (!s_axi_rvalid) report_error("RVALID dropped while RREADY was low");
      check_data(s_axi_rdata, data, "RDATA under back-pressure");
      check_resp(s_axi_rresp, resp, "RRESP under back-pressure");
    end
    s_axi_rready = 1'b1;
    @(negedge bus_clk);
    s_axi_rready = 1'b0;
    if (s_axi_rvalid) report_error("RVALID still high after the handshake");
  endtask

  task automatic read_expect(input board_pkg::reg_addr_t addr, input board_pkg::reg_data_t exp,
                             input string what);
    board_pkg::reg_data_t data;
    board_pkg::axi_resp_e resp;
    axi_read(addr, data, resp);
    check_resp(resp, board_pkg::resp_okay, what);
    check_data(data, exp, what);
  endtask

  task automatic count_expect();
    board_pkg::reg_data_t data;
    board_pkg::axi_resp_e resp;
    axi_read(32'h0c, data, resp);
    check_resp(resp, board_pkg::resp_okay, "event count response");
    check_count(data[7:0], press_model, "press count");
    check_count(data[15:8], release_model, "release count");
    check_data(data, {16'b0, release_model, press_model}, "event count word");
  endtask

  // Every change of the held level is one press or release
  task automatic set_button(input logic level);
    if (level != btn_level) begin
      if (!level && press_model != 8'hff) press_model = press_model + 8'd1;
      if (level && release_model != 8'hff) release_model = release_model + 8'd1;
    end
    btn_level  = level;
    onswitch_n = level;
  endtask

  task automatic clear_counts();
    board_pkg::axi_resp_e resp;
    axi_write(32'h0c, rand32(), 4'hf, resp);
    check_resp(resp, board_pkg::resp_okay, "count clear response");
    press_model   = '0;
    release_model = '0;
    count_expect();
  endtask

  task automatic verify_model_state();
    check_fe(fe_ctrl0, fe_model[0], "fe_ctrl0 pins");
    check_fe(fe_ctrl1, fe_model[1], "fe_ctrl1 pins");
    read_expect(32'h04, board_pkg::reg_data_t'(fe_model[0]), "fe_ctrl0 readback");
    read_expect(32'h08, board_pkg::reg_data_t'(fe_model[1]), "fe_ctrl1 readback");
    count_expect();
  endtask

  //------------------------------------------------
  // Test sequences
  //------------------------------------------------
  task automatic fe_write_sweep();
    board_pkg::reg_data_t r;
    board_pkg::reg_data_t data;
    board_pkg::axi_resp_e resp;
    logic                 sel;
    for (int i = 0; i < n_fe_writes; i++) begin
      r    = rand32();
      data = rand32();
      sel  = r[0];
      axi_write(sel ? 32'h08 : 32'h04, data, r[7:4], resp);
      check_resp(resp, board_pkg::resp_okay, "front-end write response");
      fe_model[sel] = masked_fe(fe_model[sel], data, r[7:4]);
      check_fe(fe_ctrl0, fe_model[0], "fe_ctrl0 pins");
      check_fe(fe_ctrl1, fe_model[1], "fe_ctrl1 pins");
      read_expect(sel ? 32'h08 : 32'h04, board_pkg::reg_data_t'(fe_model[sel]),
                  "front-end readback");
    end
  endtask

  task automatic status_sweep();
    board_pkg::reg_data_t r;
    board_pkg::reg_data_t exp;
    for (int i = 0; i < n_status; i++) begin
      r = rand32();
      tcxo_status_raw = r[3:0];
      lock_raw        = r[5:4];
      gps_pps         = r[6];
      set_button(r[7]);
      repeat (6) @(negedge bus_clk);
      if (pps_out !== gps_pps) report_error("pps_out does not follow the held PPS level");
      exp = {24'b0, ~btn_level, lock_raw, gps_pps, tcxo_status_raw};
      read_expect(32'h00, exp, "status register");
    end
  endtask

  task automatic button_event_run();
    int   spacing;
    int   rise_at;
    int   last_high;
    int   high_cnt;
    logic is_press;
    logic hit;
    for (int e = 0; e < n_events; e++) begin
      spacing   = 20 + int'(rand32() % 21);
      is_press  = btn_level;
      rise_at   = 0;
      last_high = 0;
      high_cnt  = 0;
      set_button(~btn_level);
      // Watch both IRQ lines over the whole stretched pulse
      for (int c = 1; c <= 14; c++) begin
        @(negedge bus_clk);
        hit = is_press ? press_irq : release_irq;
        if (is_press ? release_irq : press_irq) report_error("IRQ on the wrong event line");
        if (hit) begin
          if (high_cnt == 0) rise_at = c;
          high_cnt++;
          last_high = c;
        end
      end
      if (rise_at == 0 || rise_at > 5) report_error("IRQ did not rise within 5 cycles");
      if (high_cnt != 8 || last_high - rise_at != 7) begin
        report_error($sformatf("IRQ high for %0d cycles, expected 8 in one pulse", high_cnt));
      end
      count_expect();
      repeat (spacing - 14) @(negedge bus_clk);
    end
  endtask

  task automatic unmapped_sweep();
    board_pkg::reg_addr_t addr;
    board_pkg::reg_data_t data;
    board_pkg::axi_resp_e resp;
    for (int i = 0; i < n_unmapped; i++) begin
      addr = rand32();
      if (addr < 32'h10) addr = addr + 32'h10;
      axi_write(addr, rand32(), 4'hf, resp);
      check_resp(resp, board_pkg::resp_slverr, "unmapped write response");
      axi_read(addr, data, resp);
      check_resp(resp, board_pkg::resp_slverr, "unmapped read response");
      check_data(data, '0, "unmapped read data");
      verify_model_state();
    end
  endtask

  initial begin
    bus_rst         = 1'b1;
    onswitch_n      = 1'b1;
    gps_pps         = 1'b0;
    tcxo_status_raw = '0;
    lock_raw        = '0;
    s_axi_awaddr    = '0;
    s_axi_awvalid   = 1'b0;
    s_axi_wdata     = '0;
    s_axi_wstrb     = '0;
    s_axi_wvalid    = 1'b0;
    s_axi_bready    = 1'b0;
    s_axi_araddr    = '0;
    s_axi_arvalid   = 1'b0;
    s_axi_rready    = 1'b0;
    fe_model[0]     = '0;
    fe_model[1]     = '0;
    press_model     = '0;
    release_model   = '0;
    btn_level       = 1'b1;
    repeat (5) @(negedge bus_clk);
    bus_rst = 1'b0;
    @(negedge bus_clk);

    if (press_irq || release_irq) report_error("IRQ high after reset");
    verify_model_state();

    fe_write_sweep();
    status_sweep();
    clear_counts();
    button_event_run();
    unmapped_sweep();
    clear_counts();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/board_pkg.sv
logic/input_sync.sv
logic/button_irq_gen.sv
logic/board_ctrl_regs.sv
logic/board_glue_top.sv
tb/tb_board_glue.sv

// ==== Makefile ====
# Verilator build and run for the board glue testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_board_glue
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Result: PASSED

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
